// ==== hw/lsu_apb_master.sv ====
// APB master: runs one transfer per queued request and returns extended load data as a response
`timescale 1ns/1ps

module lsu_apb_master (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       req_valid_i,
  input  lsu_pkg::lsu_req_t          req_i,
  input  logic                       resp_ready_i,
  input  logic [lsu_pkg::XLEN-1:0]   prdata_i,
  input  logic                       pready_i,
  input  logic                       pslverr_i,
  output logic                       req_ready_o,
  output logic                       resp_valid_o,
  output logic [lsu_pkg::XLEN-1:0]   resp_rdata_o,
  output logic                       resp_err_o,
  output logic                       psel_o,
  output logic                       penable_o,
  output logic [lsu_pkg::ADDR_W-1:0] paddr_o,
  output logic                       pwrite_o,
  output logic [lsu_pkg::XLEN-1:0]   pwdata_o,
  output logic [lsu_pkg::STRB_W-1:0] pstrb_o
);

  typedef enum logic [1:0] {S_IDLE, S_SETUP, S_ACCESS, S_RESP} state_e;

  state_e                     state;
  logic                       take;
  logic                       done;
  logic [lsu_pkg::ADDR_W-1:0] paddr_q;
  logic                       pwrite_q;
  logic [lsu_pkg::XLEN-1:0]   pwdata_q;
  logic [lsu_pkg::STRB_W-1:0] pstrb_q;
  lsu_pkg::size_e             size_q;
  logic [2:0]                 off_q;
  logic                       sext_q;
  logic [lsu_pkg::XLEN-1:0]   shifted;
  logic [lsu_pkg::XLEN-1:0]   load_ext;
  logic [lsu_pkg::XLEN-1:0]   rdata_q;
  logic                       err_q;

  assign req_ready_o = (state == S_IDLE); // nothing pending
  assign take        = req_valid_i && req_ready_o;
  assign done        = (state == S_ACCESS) && pready_i;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE:   if (take) state <= req_i.mis ? S_RESP : S_SETUP; // misaligned skips the bus
        S_SETUP:  state <= S_ACCESS;
        S_ACCESS: if (pready_i) state <= S_RESP;
        default:  if (resp_ready_i) state <= S_IDLE;
      endcase
    end
  end

  // selected bytes down to bit 0, then extend
  assign shifted = prdata_i >> {off_q, 3'b000};

  always_comb begin
    case (size_q)
      lsu_pkg::SZ_B: load_ext = sext_q ? {{(lsu_pkg::XLEN-8){shifted[7]}}, shifted[7:0]}
                                       : {{(lsu_pkg::XLEN-8){1'b0}}, shifted[7:0]};
      lsu_pkg::SZ_H: load_ext = sext_q ? {{(lsu_pkg::XLEN-16){shifted[15]}}, shifted[15:0]}
                                       : {{(lsu_pkg::XLEN-16){1'b0}}, shifted[15:0]};
      lsu_pkg::SZ_W: load_ext = sext_q ? {{(lsu_pkg::XLEN-32){shifted[31]}}, shifted[31:0]}
                                       : {{(lsu_pkg::XLEN-32){1'b0}}, shifted[31:0]};
      default:       load_ext = shifted;
    endcase
  end

  always_ff @(posedge clk) begin
    if (take) begin
      paddr_q  <= req_i.addr;
      pwrite_q <= req_i.we;
      pwdata_q <= req_i.wdata;
      pstrb_q  <= req_i.strb;
      size_q   <= req_i.size;
      off_q    <= req_i.addr[2:0];
      sext_q   <= req_i.sext;
      rdata_q  <= '0;
      err_q    <= req_i.mis;
    end else if (done) begin
      rdata_q <= (pwrite_q || pslverr_i) ? '0 : load_ext; // stores answer zero
      err_q   <= pslverr_i;
    end
  end

  assign psel_o       = (state == S_SETUP) || (state == S_ACCESS);
  assign penable_o    = (state == S_ACCESS);
  assign paddr_o      = paddr_q;
  assign pwrite_o     = pwrite_q;
  assign pwdata_o     = pwdata_q;
  assign pstrb_o      = pstrb_q;
  assign resp_valid_o = (state == S_RESP);
  assign resp_rdata_o = rdata_q;
  assign resp_err_o   = err_q;

endmodule

// ==== hw/lsu_data_ram.sv ====
// data RAM behind APB: byte-strobed writes, zero wait states, error on out-of-range words
`timescale 1ns/1ps

module lsu_data_ram #(
  parameter int MEM_WORDS = 256
) (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic [lsu_pkg::ADDR_W-1:0] paddr_i,
  input  logic                       pwrite_i,
  input  logic [lsu_pkg::XLEN-1:0]   pwdata_i,
  input  logic [lsu_pkg::STRB_W-1:0] pstrb_i,
  output logic [lsu_pkg::XLEN-1:0]   prdata_o,
  output logic                       pready_o,
  output logic                       pslverr_o
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  logic [lsu_pkg::XLEN-1:0]   mem [MEM_WORDS];
  logic [lsu_pkg::ADDR_W-4:0] word_addr;
  logic [IDX_W-1:0]           idx;
  logic                       oob;
  logic                       setup;
  logic                       ready_q;
  logic                       err_q;
  logic [lsu_pkg::XLEN-1:0]   rdata_q;

  assign word_addr = paddr_i[lsu_pkg::ADDR_W-1:3];
  assign idx       = word_addr[IDX_W-1:0];
  assign oob       = (word_addr >= MEM_WORDS);
  assign setup     = psel_i && !penable_i;

  // response prepared during setup so it is there in the first access cycle
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ready_q <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      ready_q <= setup;
      err_q   <= setup && oob;
    end
  end

  always_ff @(posedge clk) begin
    if (setup) rdata_q <= oob ? '0 : mem[idx];
    if (psel_i && penable_i && pwrite_i && !oob) begin
      for (int b = 0; b < lsu_pkg::STRB_W; b++) begin
        if (pstrb_i[b]) mem[idx][b*8 +: 8] <= pwdata_i[b*8 +: 8];
      end
    end
  end

  assign pready_o  = ready_q && penable_i;
  assign pslverr_o = err_q && penable_i;
  assign prdata_o  = rdata_q;

endmodule

// ==== hw/lsu_pkg.sv ====
// shared widths, size encoding and request format for the load/store path RTL and testbench
package lsu_pkg;

  // data lane and bus widths
  parameter int XLEN   = 64;
  parameter int ADDR_W = 32;
  parameter int STRB_W = XLEN / 8;

  // access size, value is log2 of the byte count
  typedef enum logic [1:0] {
    SZ_B = 2'd0, // byte
    SZ_H = 2'd1, // half
    SZ_W = 2'd2, // word
    SZ_D = 2'd3  // double
  } size_e;

  // formatted request as stored in the request FIFO
  typedef struct packed {
    logic              we;    // store
    logic [ADDR_W-1:0] addr;  // byte address
    logic [XLEN-1:0]   wdata; // already shifted onto its lane
    logic [STRB_W-1:0] strb;  // byte enables within the lane
    size_e             size;
    logic              sext;  // sign-extend on load
    logic              mis;   // address not a multiple of the size
  } lsu_req_t;

endpackage

// ==== hw/lsu_req_fifo.sv ====
// request FIFO: circular buffer of formatted requests between the formatter and the APB master
`timescale 1ns/1ps

module lsu_req_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              wr_valid_i,
  input  lsu_pkg::lsu_req_t wr_req_i,
  input  logic              rd_ready_i,
  output logic              wr_ready_o,
  output logic              rd_valid_o,
  output lsu_pkg::lsu_req_t rd_req_o
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  lsu_pkg::lsu_req_t mem [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [PTR_W:0]    count;
  logic              full;
  logic              do_wr;
  logic              do_rd;

  assign full       = (count == FIFO_DEPTH[PTR_W:0]);
  assign rd_valid_o = (count != '0);
  assign wr_ready_o = !full || rd_ready_i; // a full buffer still takes one while a read leaves
  assign do_wr      = wr_valid_i && wr_ready_o;
  assign do_rd      = rd_valid_o && rd_ready_i;
  assign rd_req_o   = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) mem[wr_ptr] <= wr_req_i;
  end

endmodule

// ==== hw/lsu_req_format.sv ====
// request formatter: takes pipeline requests, aligns store data and strobes, flags misalignment
`timescale 1ns/1ps

module lsu_req_format (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       req_valid_i,
  input  logic                       req_we_i,
  input  logic [lsu_pkg::ADDR_W-1:0] req_addr_i,
  input  logic [lsu_pkg::XLEN-1:0]   req_wdata_i,
  input  lsu_pkg::size_e             req_size_i,
  input  logic                       req_sext_i,
  input  logic                       fmt_ready_i,
  output logic                       req_ready_o,
  output logic                       fmt_valid_o,
  output lsu_pkg::lsu_req_t          fmt_req_o
);

  logic                       rdy_en;  // low during reset, then stays high
  logic                       out_valid;
  logic                       accept;
  logic [lsu_pkg::STRB_W-1:0] strb_base;
  logic                       mis;
  lsu_pkg::lsu_req_t          fmt_d;
  lsu_pkg::lsu_req_t          out_q;

  // one-entry register, refill allowed while it drains
  assign req_ready_o = rdy_en && (!out_valid || fmt_ready_i);
  assign accept      = req_valid_i && req_ready_o;

  always_comb begin
    case (req_size_i)
      lsu_pkg::SZ_B: strb_base = 8'h01;
      lsu_pkg::SZ_H: strb_base = 8'h03;
      lsu_pkg::SZ_W: strb_base = 8'h0f;
      default:       strb_base = 8'hff;
    endcase
    case (req_size_i)
      lsu_pkg::SZ_B: mis = 1'b0;
      lsu_pkg::SZ_H: mis = req_addr_i[0];
      lsu_pkg::SZ_W: mis = |req_addr_i[1:0];
      default:       mis = |req_addr_i[2:0];
    endcase
  end

  always_comb begin
    fmt_d.we    = req_we_i;
    fmt_d.addr  = req_addr_i;
    fmt_d.wdata = req_wdata_i << {req_addr_i[2:0], 3'b000}; // byte offset to bit offset
    fmt_d.strb  = strb_base << req_addr_i[2:0];
    fmt_d.size  = req_size_i;
    fmt_d.sext  = req_sext_i;
    fmt_d.mis   = mis;
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      rdy_en    <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      rdy_en <= 1'b1;
      if (accept) out_valid <= 1'b1;
      else if (fmt_ready_i) out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) out_q <= fmt_d;
  end

  assign fmt_valid_o = out_valid;
  assign fmt_req_o   = out_q;

endmodule

// ==== hw/lsu_top.sv ====
// load/store unit top: formatter, request FIFO, APB master and data RAM wired in a chain
`timescale 1ns/1ps

module lsu_top #(
  parameter int FIFO_DEPTH = 4,
  parameter int MEM_WORDS  = 256
) (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       req_valid_i,
  input  logic                       req_we_i,
  input  logic [lsu_pkg::ADDR_W-1:0] req_addr_i,
  input  logic [lsu_pkg::XLEN-1:0]   req_wdata_i,
  input  lsu_pkg::size_e             req_size_i,
  input  logic                       req_sext_i,
  output logic                       req_ready_o,
  output logic                       resp_valid_o,
  output logic [lsu_pkg::XLEN-1:0]   resp_rdata_o,
  output logic                       resp_err_o,
  input  logic                       resp_ready_i
);

  logic                       fmt_valid;
  lsu_pkg::lsu_req_t          fmt_req;
  logic                       fifo_ready;
  logic                       fifo_valid;
  lsu_pkg::lsu_req_t          fifo_req;
  logic                       mst_ready;
  logic                       psel;
  logic                       penable;
  logic [lsu_pkg::ADDR_W-1:0] paddr;
  logic                       pwrite;
  logic [lsu_pkg::XLEN-1:0]   pwdata;
  logic [lsu_pkg::STRB_W-1:0] pstrb;
  logic [lsu_pkg::XLEN-1:0]   prdata;
  logic                       pready;
  logic                       pslverr;

  lsu_req_format u_format (
    .clk(clk), .rst_n_i(rst_n_i),
    .req_valid_i(req_valid_i), .req_we_i(req_we_i), .req_addr_i(req_addr_i),
    .req_wdata_i(req_wdata_i), .req_size_i(req_size_i), .req_sext_i(req_sext_i),
    .fmt_ready_i(fifo_ready), .req_ready_o(req_ready_o),
    .fmt_valid_o(fmt_valid), .fmt_req_o(fmt_req)
  );

  lsu_req_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
    .clk(clk), .rst_n_i(rst_n_i),
    .wr_valid_i(fmt_valid), .wr_req_i(fmt_req), .rd_ready_i(mst_ready),
    .wr_ready_o(fifo_ready), .rd_valid_o(fifo_valid), .rd_req_o(fifo_req)
  );

  lsu_apb_master u_master (
    .clk(clk), .rst_n_i(rst_n_i),
    .req_valid_i(fifo_valid), .req_i(fifo_req), .resp_ready_i(resp_ready_i),
    .prdata_i(prdata), .pready_i(pready), .pslverr_i(pslverr),
    .req_ready_o(mst_ready), .resp_valid_o(resp_valid_o),
    .resp_rdata_o(resp_rdata_o), .resp_err_o(resp_err_o),
    .psel_o(psel), .penable_o(penable), .paddr_o(paddr),
    .pwrite_o(pwrite), .pwdata_o(pwdata), .pstrb_o(pstrb)
  );

  lsu_data_ram #(.MEM_WORDS(MEM_WORDS)) u_ram (
    .clk(clk), .rst_n_i(rst_n_i),
    .psel_i(psel), .penable_i(penable), .paddr_i(paddr),
    .pwrite_i(pwrite), .pwdata_i(pwdata), .pstrb_i(pstrb),
    .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr)
  );

endmodule

// ==== lsu_top.f ====
hw/lsu_pkg.sv
hw/lsu_req_format.sv
hw/lsu_req_fifo.sv
hw/lsu_apb_master.sv
hw/lsu_data_ram.sv
hw/lsu_top.sv
sim/lsu_assert.sv
sim/lsu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the load/store unit testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module lsu_tb -f lsu_top.f

./obj_dir/Vlsu_tb 2>&1 | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi

// ==== sim/lsu_assert.sv ====
// APB handshake and response hold assertions, bound into the APB master
`timescale 1ns/1ps

module lsu_assert (
  input logic                       clk,
  input logic                       rst_n_i,
  input logic                       psel_i,
  input logic                       penable_i,
  input logic [lsu_pkg::ADDR_W-1:0] paddr_i,
  input logic                       pwrite_i,
  input logic [lsu_pkg::XLEN-1:0]   pwdata_i,
  input logic [lsu_pkg::STRB_W-1:0] pstrb_i,
  input logic                       pready_i,
  input logic                       resp_valid_i,
  input logic                       resp_ready_i,
  input logic [lsu_pkg::XLEN-1:0]   resp_rdata_i,
  input logic                       resp_err_i
);

  // access phase needs a setup cycle first, psel stays up through it
  penable_after_setup: assert property (@(posedge clk) disable iff (!rst_n_i)
    $rose(penable_i) |-> psel_i && $past(psel_i))
    else $error("penable rose without a setup cycle");

  apb_ctrl_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    psel_i && !(penable_i && pready_i) |=> $stable({paddr_i, pwrite_i, pwdata_i, pstrb_i}))
    else $error("APB address or control changed before pready");

  resp_held: assert property (@(posedge clk) disable iff (!rst_n_i)
    resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable({resp_rdata_i, resp_err_i}))
    else $error("response dropped or changed before resp_ready_i");

endmodule

bind lsu_apb_master lsu_assert u_assert (
  .clk(clk), .rst_n_i(rst_n_i),
  .psel_i(psel_o), .penable_i(penable_o), .paddr_i(paddr_o),
  .pwrite_i(pwrite_o), .pwdata_i(pwdata_o), .pstrb_i(pstrb_o), .pready_i(pready_i),
  .resp_valid_i(resp_valid_o), .resp_ready_i(resp_ready_i),
  .resp_rdata_i(resp_rdata_o), .resp_err_i(resp_err_o)
);

// ==== sim/lsu_tb.sv ====
// testbench for the load/store unit: random requests checked against a byte-array memory model
`timescale 1ns/1ps

module lsu_tb;

  localparam int TIMEOUT    = 200; // cycles allowed per handshake
  localparam int STREAM_LEN = 600;
  localparam int QUIET_LEN  = 8;   // cycles watched for a stray response at the end

  logic                       clk;
  logic                       rst_n_i;
  logic                       req_valid_i;
  logic                       req_we_i;
  logic [lsu_pkg::ADDR_W-1:0] req_addr_i;
  logic [lsu_pkg::XLEN-1:0]   req_wdata_i;
  lsu_pkg::size_e             req_size_i;
  logic                       req_sext_i;
  logic                       req_ready_o;
  logic                       resp_valid_o;
  logic [lsu_pkg::XLEN-1:0]   resp_rdata_o;
  logic                       resp_err_o;
  logic                       resp_ready_i;

  logic [7:0]               ref_mem [];      // one entry per RAM byte
  logic [lsu_pkg::XLEN-1:0] exp_data_q [$];
  logic                     exp_err_q [$];
  int                       mem_words;
  logic                     backpress;       // random resp_ready_i when set

  lsu_top u_lsu_top (
    .clk(clk), .rst_n_i(rst_n_i),
    .req_valid_i(req_valid_i), .req_we_i(req_we_i), .req_addr_i(req_addr_i),
    .req_wdata_i(req_wdata_i), .req_size_i(req_size_i), .req_sext_i(req_sext_i),
    .req_ready_o(req_ready_o), .resp_valid_o(resp_valid_o),
    .resp_rdata_o(resp_rdata_o), .resp_err_o(resp_err_o), .resp_ready_i(resp_ready_i)
  );

  always #4 clk = ~clk;

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      fail_now($sformatf("MISMATCH t=%0t %s expected %h actual %h", $time, name, exp, act));
    end
  endtask

  function automatic int size_bytes(input lsu_pkg::size_e sz);
    case (sz)
      lsu_pkg::SZ_B: return 1;
      lsu_pkg::SZ_H: return 2;
      lsu_pkg::SZ_W: return 4;
      default:       return 8;
    endcase
  endfunction

  function automatic lsu_pkg::size_e rand_size();
    logic [1:0] r;
    r = 2'($urandom);
    return lsu_pkg::size_e'(r);
  endfunction

  function automatic logic [31:0] aligned_addr(input lsu_pkg::size_e sz);
    logic [31:0] a;
    a = $urandom % (mem_words * 8);
    return a & ~(32'(size_bytes(sz)) - 32'd1);
  endfunction

  // applies one accepted request to the model and queues its expected response
  task automatic model_request(input logic we, input logic [31:0] addr,
                               input logic [63:0] wdata, input lsu_pkg::size_e sz,
                               input logic sext);
    int          nb;
    logic [63:0] val;
    logic        err;
    nb  = size_bytes(sz);
    err = (addr % nb != 0) || (addr / 8 >= mem_words);
    val = '0;
    if (!err) begin
      for (int i = 0; i < nb; i++) begin
        if (we) ref_mem[addr + i] = wdata[i*8 +: 8];
        else val[i*8 +: 8] = ref_mem[addr + i];
      end
      if (!we && sext && nb < 8 && val[nb*8-1]) begin
        for (int i = nb * 8; i < 64; i++) val[i] = 1'b1; // sign fill
      end
    end
    exp_data_q.push_back(val); // stores and errors expect zero
    exp_err_q.push_back(err);
  endtask

  // called on a falling edge, returns on the falling edge after acceptance
  task automatic send_req(input logic we, input logic [31:0] addr, input logic [63:0] wdata,
                          input lsu_pkg::size_e sz, input logic sext);
    int waited;
    req_valid_i = 1'b1;
    req_we_i    = we;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    req_size_i  = sz;
    req_sext_i  = sext;
    waited      = 0;
    while (req_ready_o !== 1'b1) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT) fail_now("timeout: req_ready_o stayed low for a pending request");
    end
    model_request(we, addr, wdata, sz, sext);
    @(negedge clk);
    req_valid_i = 1'b0;
  endtask

  // response side, handshake completes on the next rising edge
  initial begin : resp_side
    int idle;
    resp_ready_i = 1'b1;
    idle         = 0;
    forever begin
      @(negedge clk);
      resp_ready_i = backpress ? ($urandom % 3 != 0) : 1'b1;
      if (!rst_n_i || exp_data_q.size() == 0) begin
        if (resp_valid_o !== 1'b0) fail_now("response seen with no request outstanding");
        idle = 0;
      end else if (resp_valid_o && resp_ready_i) begin
        check_val("resp_rdata_o", exp_data_q.pop_front(), resp_rdata_o);
        check_val("resp_err_o", 64'(exp_err_q.pop_front()), 64'(resp_err_o));
        idle = 0;
      end else begin
        idle++;
        if (idle > TIMEOUT) fail_now("timeout: resp_valid_o handshake stalled");
      end
    end
  end

  initial begin : main
    logic [31:0]    a;
    lsu_pkg::size_e sz;
    int             waited;
    void'($urandom(32'h3b2a_dca6));
    clk         = 1'b0;
    rst_n_i     = 1'b0;
    req_valid_i = 1'b0;
    req_we_i    = 1'b0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    req_size_i  = lsu_pkg::SZ_B;
    req_sext_i  = 1'b0;
    backpress   = 1'b0;
    mem_words   = u_lsu_top.MEM_WORDS;
    ref_mem     = new[mem_words * 8];
    repeat (10) @(negedge clk);
    rst_n_i = 1'b1;
    check_val("resp_valid_o", 64'd0, 64'(resp_valid_o));
    waited = 0;
    while (req_ready_o !== 1'b1) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT) fail_now("timeout: req_ready_o never rose after reset");
    end

    // fill every word so later loads see known data
    for (int w = 0; w < mem_words; w++) begin
      send_req(1'b1, 32'(w * 8), {$urandom, $urandom}, lsu_pkg::SZ_D, 1'b0);
    end
    for (int i = 0; i < 300; i++) begin
      sz = rand_size();
      send_req(1'b1, aligned_addr(sz), {$urandom, $urandom}, sz, 1'b0);
    end
    for (int i = 0; i < 300; i++) begin
      sz = rand_size();
      send_req(1'b0, aligned_addr(sz), '0, sz, 1'($urandom));
    end

    // misaligned, then read back the whole word
    for (int i = 0; i < 20; i++) begin
      sz = lsu_pkg::size_e'(2'(1 + $urandom % 3));
      a  = aligned_addr(sz) + 1 + ($urandom % (size_bytes(sz) - 1));
      send_req(1'($urandom), a, {$urandom, $urandom}, sz, 1'($urandom));
      send_req(1'b0, {a[31:3], 3'b000}, '0, lsu_pkg::SZ_D, 1'b0);
    end

    // beyond the RAM
    for (int i = 0; i < 20; i++) begin
      sz = rand_size();
      a  = aligned_addr(sz) + 32'(mem_words * 8) * (1 + $urandom % 4);
      send_req(1'($urandom), a, {$urandom, $urandom}, sz, 1'($urandom));
    end
    send_req(1'b0, 32'hffff_fff8, '0, lsu_pkg::SZ_D, 1'b1);

    backpress = 1'b1;
    for (int i = 0; i < STREAM_LEN; i++) begin
      sz = rand_size();
      a  = aligned_addr(sz);
      case ($urandom % 16)
        0:       a = a + 32'(mem_words * 8);
        1, 2:    if (sz != lsu_pkg::SZ_B) a = a + 1;
        default: ;
      endcase
      if ($urandom % 4 == 0) @(negedge clk); // idle gap
      send_req(1'($urandom), a, {$urandom, $urandom}, sz, 1'($urandom));
    end

    waited = 0;
    while (exp_data_q.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT * 4) fail_now("timeout: outstanding responses never drained");
    end
    backpress = 1'b0;
    // a duplicated response would show up after the last expected one
    for (int i = 0; i < QUIET_LEN; i++) begin
      @(negedge clk);
      check_val("resp_valid_o", 64'd0, 64'(resp_valid_o));
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule
